// File: rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath width
`define XLEN 32

// Architectural register count
`define REG_NUM 32

// Data memory depth in 32-bit words (1 KiB)
`define DMEM_WORDS 256

// Machine-mode CSR addresses
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC    12'h305
`define CSR_MEPC     12'h341

`endif

// File: rv_isa_pkg.sv
`include "rv_macros.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_addr_t;
    typedef logic [11:0]      csr_addr_t;

    // Source of the value written to rd
    typedef enum logic [2:0] {
        RD_WRB_ALU    = 3'd0,
        RD_WRB_INC_PC = 3'd1,
        RD_WRB_DMEM   = 3'd2,
        RD_WRB_CSR    = 3'd3,
        RD_WRB_M_ALU  = 3'd4
    } rd_wrb_sel_e;

    // Load and store operations
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        LB       = 4'd1,
        LH       = 4'd2,
        LW       = 4'd3,
        LBU      = 4'd4,
        LHU      = 4'd5,
        SB       = 4'd6,
        SH       = 4'd7,
        SW       = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_RC   = 2'd3
    } csr_op_e;

    typedef enum logic [2:0] {
        MUL_NONE = 3'd0,
        MUL      = 3'd1,
        MULH     = 3'd2,
        MULHSU   = 3'd3,
        MULHU    = 3'd4
    } mul_op_e;

endpackage : rv_isa_pkg

// File: rv_pipe_pkg.sv
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Already-executed operation entering the memory stage
    typedef struct packed {
        logic        valid;
        word_t       alu_result;
        word_t       pc_next;
        reg_addr_t   rd_addr;
        logic        rd_wr_req;
        rd_wrb_sel_e rd_wrb_sel;
        mem_op_e     mem_op;
        word_t       store_data;
        csr_op_e     csr_op;
        csr_addr_t   csr_addr;
        word_t       csr_wdata;
        mul_op_e     mul_op;
        word_t       mul_a;
        word_t       mul_b;
    } type_exe2lsu_s;

    typedef struct packed {
        word_t     alu_result;
        word_t     pc_next;
        word_t     r_data;
        reg_addr_t rd_addr;
    } type_lsu2wrb_data_s;

    typedef struct packed {
        logic        rd_wr_req;
        rd_wrb_sel_e rd_wrb_sel;
    } type_lsu2wrb_ctrl_s;

    typedef struct packed {
        word_t csr_rdata;
    } type_csr2wrb_data_s;

    typedef struct packed {
        word_t alu_m_result;
    } type_mul2wrb_s;

    // Register file write request
    typedef struct packed {
        word_t     rd_data;
        reg_addr_t rd_addr;
        logic      rd_wr_req;
    } type_wrb2id_fb_s;

    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_wr_req;
    } type_wrb2fwd_s;

    // Memory-stage destination that is ready only when its value is already known
    typedef struct packed {
        reg_addr_t rd_addr;
        logic      rd_wr_req;
        word_t     rd_data;
        logic      ready;
    } type_lsu2fwd_s;

endpackage : rv_pipe_pkg

// File: lsu.sv
`include "rv_macros.svh"

module lsu (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  wire rv_pipe_pkg::type_exe2lsu_s exe2lsu_i,
    output rv_pipe_pkg::type_lsu2wrb_data_s lsu2wrb_data_o,
    output rv_pipe_pkg::type_lsu2wrb_ctrl_s lsu2wrb_ctrl_o,
    output rv_pipe_pkg::type_lsu2fwd_s      lsu2fwd_o
);

    import rv_isa_pkg::*;

    localparam int AW = $clog2(`DMEM_WORDS);

    // Memory-stage register
    logic        mem_valid;
    logic        mem_rd_wr_req;
    rd_wrb_sel_e mem_wrb_sel;
    mem_op_e     mem_op;
    word_t       mem_alu_result;
    word_t       mem_pc_next;
    word_t       mem_store_data;
    reg_addr_t   mem_rd_addr;

    word_t          dmem [`DMEM_WORDS];
    logic [AW-1:0]  word_idx;
    word_t          rd_word;
    word_t          rd_shifted;
    word_t          load_data;
    word_t          st_wdata;
    logic [3:0]     st_be;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_valid     <= 1'b0;
            mem_rd_wr_req <= 1'b0;
            mem_wrb_sel   <= RD_WRB_ALU;
            mem_op        <= MEM_NONE;
        end else begin
            mem_valid     <= exe2lsu_i.valid;
            mem_rd_wr_req <= exe2lsu_i.valid & exe2lsu_i.rd_wr_req;
            mem_wrb_sel   <= exe2lsu_i.rd_wrb_sel;
            mem_op        <= exe2lsu_i.mem_op;
        end
        mem_alu_result <= exe2lsu_i.alu_result;
        mem_pc_next    <= exe2lsu_i.pc_next;
        mem_store_data <= exe2lsu_i.store_data;
        mem_rd_addr    <= exe2lsu_i.rd_addr;
    end

    assign word_idx   = mem_alu_result[AW+1:2];
    assign rd_word    = dmem[word_idx];
    assign rd_shifted = rd_word >> {mem_alu_result[1:0], 3'b000};

    // Load extraction with sign or zero extension
    always_comb begin
        case (mem_op)
            LB:      load_data = {{(`XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
            LH:      load_data = {{(`XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
            LBU:     load_data = {{(`XLEN-8){1'b0}}, rd_shifted[7:0]};
            LHU:     load_data = {{(`XLEN-16){1'b0}}, rd_shifted[15:0]};
            default: load_data = rd_word;
        endcase
    end

    // Store lanes use replicated data and a shifted byte enable
    always_comb begin
        st_wdata = mem_store_data;
        st_be    = 4'b0000;
        case (mem_op)
            SB: begin
                st_wdata = {4{mem_store_data[7:0]}};
                st_be    = 4'b0001 << mem_alu_result[1:0];
            end
            SH: begin
                st_wdata = {2{mem_store_data[15:0]}};
                st_be    = 4'b0011 << mem_alu_result[1:0];
            end
            SW: st_be = 4'b1111;
            default: st_be = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (mem_valid && st_be[i]) begin
                dmem[word_idx][8*i +: 8] <= st_wdata[8*i +: 8];
            end
        end
    end

    // Results toward writeback
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lsu2wrb_ctrl_o.rd_wr_req  <= 1'b0;
            lsu2wrb_ctrl_o.rd_wrb_sel <= RD_WRB_ALU;
        end else begin
            lsu2wrb_ctrl_o.rd_wr_req  <= mem_rd_wr_req;
            lsu2wrb_ctrl_o.rd_wrb_sel <= mem_wrb_sel;
        end
        lsu2wrb_data_o.alu_result <= mem_alu_result;
        lsu2wrb_data_o.pc_next    <= mem_pc_next;
        lsu2wrb_data_o.r_data     <= load_data;
        lsu2wrb_data_o.rd_addr    <= mem_rd_addr;
    end

    assign lsu2fwd_o.rd_addr   = mem_rd_addr;
    assign lsu2fwd_o.rd_wr_req = mem_rd_wr_req;
    assign lsu2fwd_o.rd_data   = (mem_wrb_sel == RD_WRB_INC_PC) ? mem_pc_next : mem_alu_result;
    assign lsu2fwd_o.ready     = (mem_wrb_sel == RD_WRB_ALU) || (mem_wrb_sel == RD_WRB_INC_PC);

endmodule : lsu

// File: mul_unit.sv
`include "rv_macros.svh"

module mul_unit (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  wire rv_pipe_pkg::type_exe2lsu_s exe2lsu_i,
    output rv_pipe_pkg::type_mul2wrb_s      mul2wrb_o
);

    import rv_isa_pkg::*;

    mul_op_e                   op_q;
    word_t                     a_q;
    word_t                     b_q;
    logic                      a_signed;
    logic                      b_signed;
    logic signed [2*`XLEN+1:0] a_ext;
    logic signed [2*`XLEN+1:0] b_ext;
    logic signed [2*`XLEN+1:0] prod_full;
    logic [2*`XLEN-1:0]        product;

    // Operands captured alongside the LSU memory-stage register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op_q <= MUL_NONE;
        end else begin
            op_q <= exe2lsu_i.valid ? exe2lsu_i.mul_op : MUL_NONE;
        end
        a_q <= exe2lsu_i.mul_a;
        b_q <= exe2lsu_i.mul_b;
    end

    assign a_signed = (op_q == MULH) || (op_q == MULHSU);
    assign b_signed = (op_q == MULH);

    // Sign or zero extension to the product width covers signed, unsigned and mixed forms
    assign a_ext     = {{(`XLEN+2){a_signed & a_q[`XLEN-1]}}, a_q};
    assign b_ext     = {{(`XLEN+2){b_signed & b_q[`XLEN-1]}}, b_q};
    assign prod_full = a_ext * b_ext;
    assign product   = prod_full[2*`XLEN-1:0];

    always_ff @(posedge clk) begin
        case (op_q)
            MUL:                  mul2wrb_o.alu_m_result <= product[`XLEN-1:0];
            MULH, MULHSU, MULHU:  mul2wrb_o.alu_m_result <= product[2*`XLEN-1:`XLEN];
            default:              mul2wrb_o.alu_m_result <= '0;
        endcase
    end

endmodule : mul_unit

// File: csr_file.sv
`include "rv_macros.svh"

module csr_file (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  wire rv_pipe_pkg::type_exe2lsu_s     exe2lsu_i,
    output rv_pipe_pkg::type_csr2wrb_data_s     csr2wrb_data_o
);

    import rv_isa_pkg::*;

    csr_op_e   op_q;
    csr_addr_t addr_q;
    word_t     wdata_q;

    word_t     mscratch;
    word_t     mtvec;
    word_t     mepc;

    word_t     old_val;
    word_t     new_val;
    logic      addr_hit;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            op_q <= CSR_NONE;
        end else begin
            op_q <= exe2lsu_i.valid ? exe2lsu_i.csr_op : CSR_NONE;
        end
        addr_q  <= exe2lsu_i.csr_addr;
        wdata_q <= exe2lsu_i.csr_wdata;
    end

    // Unknown addresses read as zero
    always_comb begin
        addr_hit = 1'b1;
        case (addr_q)
            `CSR_MSCRATCH: old_val = mscratch;
            `CSR_MTVEC:    old_val = mtvec;
            `CSR_MEPC:     old_val = mepc;
            default: begin
                old_val  = '0;
                addr_hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (op_q)
            CSR_RS:  new_val = old_val | wdata_q;
            CSR_RC:  new_val = old_val & ~wdata_q;
            default: new_val = wdata_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
        end else if (op_q != CSR_NONE && addr_hit) begin
            case (addr_q)
                `CSR_MSCRATCH: mscratch <= new_val;
                `CSR_MTVEC:    mtvec    <= new_val;
                default:       mepc     <= new_val;
            endcase
        end
        csr2wrb_data_o.csr_rdata <= old_val;
    end

endmodule : csr_file

// File: writeback.sv
module writeback (
    input  wire rv_pipe_pkg::type_lsu2wrb_data_s lsu2wrb_data_i,
    input  wire rv_pipe_pkg::type_lsu2wrb_ctrl_s lsu2wrb_ctrl_i,
    input  wire rv_pipe_pkg::type_csr2wrb_data_s csr2wrb_data_i,
    input  wire rv_pipe_pkg::type_mul2wrb_s      mul2wrb_i,
    output rv_pipe_pkg::type_wrb2id_fb_s         wrb2id_fb_o,
    output rv_isa_pkg::word_t                    wrb2exe_fb_rd_data_o,
    output rv_pipe_pkg::type_wrb2fwd_s           wrb2fwd_o
);

    import rv_isa_pkg::*;

    word_t rd_data;

    // Destination value from one of five sources
    always_comb begin
        case (lsu2wrb_ctrl_i.rd_wrb_sel)
            RD_WRB_ALU:    rd_data = lsu2wrb_data_i.alu_result;
            RD_WRB_INC_PC: rd_data = lsu2wrb_data_i.pc_next;
            RD_WRB_DMEM:   rd_data = lsu2wrb_data_i.r_data;
            RD_WRB_CSR:    rd_data = csr2wrb_data_i.csr_rdata;
            RD_WRB_M_ALU:  rd_data = mul2wrb_i.alu_m_result;
            default:       rd_data = '0;
        endcase
    end

    assign wrb2id_fb_o.rd_data   = rd_data;
    assign wrb2id_fb_o.rd_addr   = lsu2wrb_data_i.rd_addr;
    assign wrb2id_fb_o.rd_wr_req = lsu2wrb_ctrl_i.rd_wr_req;

    assign wrb2exe_fb_rd_data_o  = rd_data;

    assign wrb2fwd_o.rd_addr     = lsu2wrb_data_i.rd_addr;
    assign wrb2fwd_o.rd_wr_req   = lsu2wrb_ctrl_i.rd_wr_req;

endmodule : writeback

// File: regfile.sv
`include "rv_macros.svh"

module regfile (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  wire rv_pipe_pkg::type_wrb2id_fb_s wrb2id_fb_i,
    input  rv_isa_pkg::reg_addr_t             rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t             rs2_addr_i,
    output rv_isa_pkg::word_t                 rs1_data_o,
    output rv_isa_pkg::word_t                 rs2_data_o
);

    import rv_isa_pkg::*;

    word_t regs [`REG_NUM];

    // x0 is never written so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrb2id_fb_i.rd_wr_req && wrb2id_fb_i.rd_addr != '0) begin
            regs[wrb2id_fb_i.rd_addr] <= wrb2id_fb_i.rd_data;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule : regfile

// File: forward_stall.sv
module forward_stall (
    input  rv_isa_pkg::reg_addr_t            rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t            rs2_addr_i,
    input  rv_isa_pkg::word_t                rf_rs1_data_i,
    input  rv_isa_pkg::word_t                rf_rs2_data_i,
    input  wire rv_pipe_pkg::type_lsu2fwd_s  lsu2fwd_i,
    input  wire rv_pipe_pkg::type_wrb2fwd_s  wrb2fwd_i,
    input  rv_isa_pkg::word_t                wrb_rd_data_i,
    output rv_isa_pkg::word_t                rs1_data_o,
    output rv_isa_pkg::word_t                rs2_data_o,
    output logic                             stall_o
);

    import rv_isa_pkg::*;

    logic mem_hit1;
    logic mem_hit2;
    logic wrb_hit1;
    logic wrb_hit2;

    assign mem_hit1 = lsu2fwd_i.rd_wr_req && rs1_addr_i != '0 && lsu2fwd_i.rd_addr == rs1_addr_i;
    assign mem_hit2 = lsu2fwd_i.rd_wr_req && rs2_addr_i != '0 && lsu2fwd_i.rd_addr == rs2_addr_i;
    assign wrb_hit1 = wrb2fwd_i.rd_wr_req && rs1_addr_i != '0 && wrb2fwd_i.rd_addr == rs1_addr_i;
    assign wrb_hit2 = wrb2fwd_i.rd_wr_req && rs2_addr_i != '0 && wrb2fwd_i.rd_addr == rs2_addr_i;

    // Newest value first and a not-ready memory-stage match falls through
    assign rs1_data_o = (rs1_addr_i == '0)           ? '0 :
                        (mem_hit1 && lsu2fwd_i.ready) ? lsu2fwd_i.rd_data :
                        wrb_hit1                      ? wrb_rd_data_i : rf_rs1_data_i;
    assign rs2_data_o = (rs2_addr_i == '0)           ? '0 :
                        (mem_hit2 && lsu2fwd_i.ready) ? lsu2fwd_i.rd_data :
                        wrb_hit2                      ? wrb_rd_data_i : rf_rs2_data_i;

    // Load, CSR and multiply results are not known until writeback
    assign stall_o = (mem_hit1 || mem_hit2) && !lsu2fwd_i.ready;

endmodule : forward_stall

// File: backend_top.sv
module backend_top (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  wire rv_pipe_pkg::type_exe2lsu_s   exe2lsu_i,
    input  rv_isa_pkg::reg_addr_t             rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t             rs2_addr_i,
    output rv_isa_pkg::word_t                 rs1_data_o,
    output rv_isa_pkg::word_t                 rs2_data_o,
    output logic                              stall_o,
    output rv_pipe_pkg::type_wrb2id_fb_s      wrb_fb_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    type_lsu2wrb_data_s lsu2wrb_data;
    type_lsu2wrb_ctrl_s lsu2wrb_ctrl;
    type_lsu2fwd_s      lsu2fwd;
    type_csr2wrb_data_s csr2wrb_data;
    type_mul2wrb_s      mul2wrb;
    type_wrb2id_fb_s    wrb2id_fb;
    type_wrb2fwd_s      wrb2fwd;
    word_t              wrb_rd_data;
    word_t              rf_rs1_data;
    word_t              rf_rs2_data;

    // Three memory-stage units fed by the same issued operation
    lsu u_lsu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .exe2lsu_i      (exe2lsu_i),
        .lsu2wrb_data_o (lsu2wrb_data),
        .lsu2wrb_ctrl_o (lsu2wrb_ctrl),
        .lsu2fwd_o      (lsu2fwd)
    );

    csr_file u_csr_file (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .exe2lsu_i      (exe2lsu_i),
        .csr2wrb_data_o (csr2wrb_data)
    );

    mul_unit u_mul_unit (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .exe2lsu_i (exe2lsu_i),
        .mul2wrb_o (mul2wrb)
    );

    writeback u_writeback (
        .lsu2wrb_data_i       (lsu2wrb_data),
        .lsu2wrb_ctrl_i       (lsu2wrb_ctrl),
        .csr2wrb_data_i       (csr2wrb_data),
        .mul2wrb_i            (mul2wrb),
        .wrb2id_fb_o          (wrb2id_fb),
        .wrb2exe_fb_rd_data_o (wrb_rd_data),
        .wrb2fwd_o            (wrb2fwd)
    );

    regfile u_regfile (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wrb2id_fb_i (wrb2id_fb),
        .rs1_addr_i  (rs1_addr_i),
        .rs2_addr_i  (rs2_addr_i),
        .rs1_data_o  (rf_rs1_data),
        .rs2_data_o  (rf_rs2_data)
    );

    forward_stall u_forward_stall (
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .lsu2fwd_i     (lsu2fwd),
        .wrb2fwd_i     (wrb2fwd),
        .wrb_rd_data_i (wrb_rd_data),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .stall_o       (stall_o)
    );

    assign wrb_fb_o = wrb2id_fb;

endmodule : backend_top

// File: tb_backend.sv
`include "rv_macros.svh"

module tb_backend;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int NUM_OPS     = 2000;
    localparam int CYCLE_LIMIT = NUM_OPS + 100;

    // Expected result of one operation as it moves down the pipeline
    typedef struct packed {
        logic      wr;
        reg_addr_t rd;
        word_t     data;
        logic      known;
        logic      ready;
    } exp_s;

    logic            clk = 1'b0;
    logic            rst_n;
    type_exe2lsu_s   exe2lsu;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    word_t           rs1_data;
    word_t           rs2_data;
    logic            stall;
    type_wrb2id_fb_s wrb_fb;

    integer seed = 32'h8fee_5d48;
    int     cycle_cnt = 0;
    int     err_reset = 0;
    int     err_wb = 0;
    int     err_rd = 0;
    int     err_stall = 0;

    // Reference model state
    word_t      regs_m [`REG_NUM];
    logic       reg_known [`REG_NUM];
    logic [7:0] mem_b [4*`DMEM_WORDS];
    logic       byte_known [4*`DMEM_WORDS];
    word_t      csr_m [3];
    exp_s       pipe_q [$];

    backend_top dut (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .exe2lsu_i  (exe2lsu),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .stall_o    (stall),
        .wrb_fb_o   (wrb_fb)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the cycle limit was reached before all operations were checked");
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int bytes_of(input mem_op_e m);
        case (m)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    // Low 64 bytes or top 64 bytes of the data memory, aligned to the access size
    function automatic word_t pick_addr(input int nb);
        word_t a;
        a = $unsigned($random(seed)) & 32'h3f;
        if ($random(seed) & 1)
            a = a | 32'h3c0;
        return a & ~word_t'(nb - 1);
    endfunction

    function automatic csr_addr_t csr_addr_of(input int ci);
        case (ci)
            0:       return `CSR_MSCRATCH;
            1:       return `CSR_MTVEC;
            2:       return `CSR_MEPC;
            default: return 12'h7c0;
        endcase
    endfunction

    // Builds a random operation and applies its effect to the model in program order
    task automatic make_op(input bit live, output type_exe2lsu_s op, output exp_s e);
        int          kind;
        int          sub;
        int          nb;
        int          ci;
        word_t       addr;
        word_t       raw;
        word_t       old_val;
        logic [9:0]  idx;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        op            = '0;
        op.valid      = 1'b1;
        op.alu_result = $random(seed);
        op.pc_next    = $random(seed);
        op.store_data = $random(seed);
        op.csr_wdata  = $random(seed);
        op.mul_a      = $random(seed);
        op.mul_b      = $random(seed);
        op.rd_addr    = 5'($unsigned($random(seed)) % 16);
        op.rd_wr_req  = 1'b1;
        op.rd_wrb_sel = RD_WRB_ALU;
        op.mem_op     = MEM_NONE;
        op.csr_op     = CSR_NONE;
        op.mul_op     = MUL_NONE;
        e.wr    = 1'b1;
        e.rd    = op.rd_addr;
        e.data  = op.alu_result;
        e.known = 1'b1;
        e.ready = 1'b1;
        kind = live ? $unsigned($random(seed)) % 8 : 7;
        sub  = $unsigned($random(seed)) % 5;
        case (kind)
            0, 1: op.rd_wrb_sel = RD_WRB_ALU;
            2: begin
                op.rd_wrb_sel = RD_WRB_INC_PC;
                e.data = op.pc_next;
            end
            3: begin
                op.mem_op     = mem_op_e'(4'(1 + sub));
                op.rd_wrb_sel = RD_WRB_DMEM;
                nb   = bytes_of(op.mem_op);
                addr = pick_addr(nb);
                op.alu_result = addr;
                raw  = '0;
                for (int i = 0; i < nb; i++) begin
                    idx = addr[9:0] + 10'(i);
                    raw[8*i +: 8] = mem_b[idx];
                    e.known &= byte_known[idx];
                end
                case (op.mem_op)
                    LB:      e.data = {{24{raw[7]}}, raw[7:0]};
                    LH:      e.data = {{16{raw[15]}}, raw[15:0]};
                    default: e.data = raw;
                endcase
                e.ready = 1'b0;
            end
            4: begin
                op.mem_op    = mem_op_e'(4'(6 + (sub % 3)));
                op.rd_wr_req = 1'b0;
                e.wr = 1'b0;
                nb   = bytes_of(op.mem_op);
                addr = pick_addr(nb);
                op.alu_result = addr;
                for (int i = 0; i < nb; i++) begin
                    idx = addr[9:0] + 10'(i);
                    mem_b[idx]      = op.store_data[8*i +: 8];
                    byte_known[idx] = 1'b1;
                end
            end
            5: begin
                ci = sub % 4;
                op.csr_op     = csr_op_e'(2'(1 + ($unsigned($random(seed)) % 3)));
                op.csr_addr   = csr_addr_of(ci);
                op.rd_wrb_sel = RD_WRB_CSR;
                old_val = (ci < 3) ? csr_m[ci] : '0;
                if (ci < 3) begin
                    case (op.csr_op)
                        CSR_RS:  csr_m[ci] = old_val | op.csr_wdata;
                        CSR_RC:  csr_m[ci] = old_val & ~op.csr_wdata;
                        default: csr_m[ci] = op.csr_wdata;
                    endcase
                end
                e.data  = old_val;
                e.ready = 1'b0;
            end
            6: begin
                op.mul_op     = mul_op_e'(3'(1 + (sub % 4)));
                op.rd_wrb_sel = RD_WRB_M_ALU;
                ea = {32'b0, op.mul_a};
                eb = {32'b0, op.mul_b};
                if (op.mul_op == MULH || op.mul_op == MULHSU)
                    ea = {{32{op.mul_a[31]}}, op.mul_a};
                if (op.mul_op == MULH)
                    eb = {{32{op.mul_b[31]}}, op.mul_b};
                prod   = ea * eb;
                e.data  = (op.mul_op == MUL) ? prod[31:0] : prod[63:32];
                e.ready = 1'b0;
            end
            default: begin
                // Bubble with live-looking fields that must have no effect
                op.valid    = 1'b0;
                op.mem_op   = SW;
                op.csr_op   = CSR_RW;
                op.csr_addr = `CSR_MSCRATCH;
                op.mul_op   = MUL;
                e.wr = 1'b0;
            end
        endcase
    endtask

    task automatic retire(input exp_s e);
        if (e.wr && e.rd != '0) begin
            regs_m[e.rd]    = e.data;
            reg_known[e.rd] = e.known;
        end
    endtask

    // Memory stage first, then writeback, then the register file
    function automatic void expect_read(input reg_addr_t a, output word_t d,
                                        output logic known, output logic stall_hit);
        exp_s wb;
        exp_s mem;
        wb        = pipe_q[0];
        mem       = pipe_q[1];
        d         = '0;
        known     = 1'b1;
        stall_hit = 1'b0;
        if (a != '0) begin
            if (mem.wr && mem.rd == a) begin
                if (mem.ready)
                    d = mem.data;
                else
                    stall_hit = 1'b1;
            end else if (wb.wr && wb.rd == a) begin
                d     = wb.data;
                known = wb.known;
            end else begin
                d     = regs_m[a];
                known = reg_known[a];
            end
        end
    endfunction

    task automatic check_outputs();
        exp_s  wb;
        word_t d1;
        word_t d2;
        logic  k1;
        logic  k2;
        logic  s1;
        logic  s2;
        wb = pipe_q[0];
        if (wrb_fb.rd_wr_req !== wb.wr) begin
            err_wb++;
            $display("[FAIL] %0t: writeback rd_wr_req %b, expected %b", $time,
                     wrb_fb.rd_wr_req, wb.wr);
        end else if (wb.wr) begin
            if (wrb_fb.rd_addr !== wb.rd) begin
                err_wb++;
                $display("[FAIL] %0t: writeback rd x%0d, expected x%0d", $time,
                         wrb_fb.rd_addr, wb.rd);
            end
            if (wb.known && wrb_fb.rd_data !== wb.data) begin
                err_wb++;
                $display("[FAIL] %0t: writeback data %h, expected %h", $time,
                         wrb_fb.rd_data, wb.data);
            end
        end
        expect_read(rs1_addr, d1, k1, s1);
        expect_read(rs2_addr, d2, k2, s2);
        if (stall !== (s1 || s2)) begin
            err_stall++;
            $display("[FAIL] %0t: stall %b, expected %b", $time, stall, s1 || s2);
        end
        if (!s1 && k1 && rs1_data !== d1) begin
            err_rd++;
            $display("[FAIL] %0t: rs1 x%0d read %h, expected %h", $time, rs1_addr, rs1_data, d1);
        end
        if (!s2 && k2 && rs2_data !== d2) begin
            err_rd++;
            $display("[FAIL] %0t: rs2 x%0d read %h, expected %h", $time, rs2_addr, rs2_data, d2);
        end
    endtask

    initial begin
        type_exe2lsu_s op;
        exp_s          e;
        rst_n    = 1'b0;
        exe2lsu  = '0;
        rs1_addr = 5'd3;
        rs2_addr = 5'd17;
        for (int i = 0; i < `REG_NUM; i++) begin
            regs_m[i]    = '0;
            reg_known[i] = 1'b1;
        end
        for (int i = 0; i < 4*`DMEM_WORDS; i++)
            byte_known[i] = 1'b0;
        for (int i = 0; i < 3; i++) begin
            csr_m[i] = '0;
            pipe_q.push_back('0);
        end
        repeat (15) @(posedge clk);
        @(negedge clk);
        if (wrb_fb.rd_wr_req !== 1'b0 || stall !== 1'b0) begin
            err_reset++;
            $display("[FAIL] %0t: writeback request or stall active in reset", $time);
        end
        if (rs1_data !== '0 || rs2_data !== '0) begin
            err_reset++;
            $display("[FAIL] %0t: read ports %h %h in reset, expected 0", $time, rs1_data, rs2_data);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        // Three trailing bubbles drain the pipeline
        for (int n = 0; n < NUM_OPS + 3; n++) begin
            @(posedge clk);
            retire(pipe_q.pop_front());
            make_op(n < NUM_OPS, op, e);
            pipe_q.push_back(e);
            exe2lsu  <= op;
            rs1_addr <= 5'($unsigned($random(seed)) % 16);
            rs2_addr <= 5'($unsigned($random(seed)) % 16);
            @(negedge clk);
            check_outputs();
        end
        $display("Error counts: reset %0d, writeback %0d, read %0d, stall %0d",
                 err_reset, err_wb, err_rd, err_stall);
        if (err_reset + err_wb + err_rd + err_stall == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_backend

// File: project.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
lsu.sv
mul_unit.sv
csr_file.sv
writeback.sv
regfile.sv
forward_stall.sv
backend_top.sv
tb_backend.sv

// File: Makefile
TOP = tb_backend

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f project.f --Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
